//--- verilog/tkrMergePkg.sv
/*
 * Shared types and constants for the tracker event merger.
 * Covers the chip word layouts, the frame field layouts and the merge FSM encoding.
 * Modules refer to these by scoped names.
 */
package tkrMergePkg;

    localparam int WordBits  = 12; // Chip words and all frame fields but the start string
    localparam int StartBits = 6;  // Start prefix plus board address
    localparam int MaxChips  = 15; // Chip index is 4 bits wide

    localparam logic [1:0] StartPrefix = 2'b10;

    // Event header word as it comes out of a front-end chip
    typedef struct packed {
        logic [1:0] spareHi;
        logic [1:0] tag;
        logic       chipErr;
        logic       spareMid;
        logic       overflow;
        logic       spareLo;
        logic [3:0] nClus;
    } chipHeader_t;

    // A chip presents its header first and then its cluster words on the same 12 bits
    typedef union packed {
        chipHeader_t                header;
        logic [WordBits-1:0]        cluster;
    } chipWord_t;

    typedef struct packed {
        logic [4:0] evtNum;
        logic [1:0] tag;
        logic       tagErr;
        logic [3:0] nChipsWithClus;
    } eventHeader_t;

    typedef struct packed {
        logic       overflow;
        logic       zeroHi;
        logic [3:0] nClus;
        logic       chipErr;
        logic       zeroLo;   // Parity bit position, always sent as 0
        logic [3:0] chip;
    } chipFrameHeader_t;

    typedef enum logic [1:0] {FieldStart, FieldEvent, FieldChip, FieldCluster} frameField_t;

    typedef enum logic [6:0] {
        IdleSt     = 7'b0000001,
        LatchSt    = 7'b0000010,
        StartSt    = 7'b0000100,
        EventHdrSt = 7'b0001000,
        ChipHdrSt  = 7'b0010000,
        ClusterSt  = 7'b0100000,
        SpaceSt    = 7'b1000000
    } mergeState_t;

endpackage

//--- verilog/mergeControl.sv
/*
 * Frame FSM of the merger. Waits for all unmasked chips and a pending request,
 * then steps through start string, event header, chip headers and cluster words
 * with no gap between fields. Also pulls chip words with the strobe handshake.
 */
`timescale 1ns/10ps

module mergeControl #(
    parameter int NumChips = 12
) (
    input  logic                     Clock,
    input  logic                     reset,
    input  logic [NumChips-1:0]      Mask,
    input  logic [NumChips-1:0]      ChipReady,
    input  logic                     HavePending,
    input  logic                     NoMoreChips,
    input  logic [3:0]               NextChip,
    input  logic [3:0]               NClusCurrent,
    input  logic                     TagErr,
    output logic [NumChips-1:0]      Strobe,
    output logic                     LatchHeaders,
    output tkrMergePkg::frameField_t LoadField,
    output logic                     LoadEnable,
    output logic                     ShiftEnable,
    output logic [3:0]               CurrentChip,
    output logic                     AdvanceChip,
    output logic                     FrameDone,
    output logic                     ErrorOut
);

    localparam logic [3:0] StartLast = 4'(tkrMergePkg::StartBits - 1);
    localparam logic [3:0] WordLast  = 4'(tkrMergePkg::WordBits - 1);

    tkrMergePkg::mergeState_t state, nextState;
    logic [3:0]          bitCnt;   // Bit position inside the current field
    logic [3:0]          clusCnt;  // Cluster words loaded so far for the current chip
    logic                allReady, fieldEnd, moreClus;
    logic [NumChips-1:0] chipBit;

    assign allReady = &(ChipReady | ~Mask);  // Masked chips never hold up a frame
    assign fieldEnd = (state == tkrMergePkg::StartSt) ? (bitCnt == StartLast)
                                                      : (bitCnt == WordLast);
    assign moreClus = (clusCnt < NClusCurrent);
    assign chipBit  = NumChips'(1) << CurrentChip;

    assign LatchHeaders = (state == tkrMergePkg::LatchSt);
    assign ShiftEnable  = state inside {tkrMergePkg::StartSt, tkrMergePkg::EventHdrSt,
                                        tkrMergePkg::ChipHdrSt, tkrMergePkg::ClusterSt};
    assign FrameDone    = (state == tkrMergePkg::SpaceSt);
    assign ErrorOut     = TagErr && (state == tkrMergePkg::EventHdrSt) && (bitCnt == 4'd0);

    // Each field end loads the following field so the output never pauses
    always_comb begin
        nextState   = state;
        LoadEnable  = 1'b0;
        LoadField   = tkrMergePkg::FieldStart;
        AdvanceChip = 1'b0;
        case (state)
            tkrMergePkg::IdleSt: begin
                if (allReady && HavePending) nextState = tkrMergePkg::LatchSt;
            end
            tkrMergePkg::LatchSt: begin
                nextState  = tkrMergePkg::StartSt;
                LoadEnable = 1'b1;
            end
            tkrMergePkg::StartSt: begin
                if (fieldEnd) begin
                    nextState  = tkrMergePkg::EventHdrSt;
                    LoadEnable = 1'b1;
                    LoadField  = tkrMergePkg::FieldEvent;
                end
            end
            tkrMergePkg::ChipHdrSt: begin
                if (fieldEnd) begin
                    nextState  = tkrMergePkg::ClusterSt;
                    LoadEnable = 1'b1;
                    LoadField  = tkrMergePkg::FieldCluster;
                end
            end
            tkrMergePkg::EventHdrSt, tkrMergePkg::ClusterSt: begin
                if (fieldEnd) begin
                    if (state == tkrMergePkg::ClusterSt && moreClus) begin
                        LoadEnable = 1'b1;
                        LoadField  = tkrMergePkg::FieldCluster;
                    end else if (NoMoreChips) begin
                        nextState = tkrMergePkg::SpaceSt;
                    end else begin
                        nextState   = tkrMergePkg::ChipHdrSt;
                        LoadEnable  = 1'b1;
                        LoadField   = tkrMergePkg::FieldChip;
                        AdvanceChip = 1'b1;
                    end
                end
            end
            default: nextState = tkrMergePkg::IdleSt;  // Space lasts one cycle
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            state       <= tkrMergePkg::IdleSt;
            bitCnt      <= '0;
            clusCnt     <= '0;
            CurrentChip <= '0;
            Strobe      <= '0;
        end else begin
            state  <= nextState;
            bitCnt <= (LoadEnable || !ShiftEnable) ? 4'd0 : bitCnt + 4'd1;
            Strobe <= '0;
            if (state == tkrMergePkg::IdleSt && nextState == tkrMergePkg::LatchSt) begin
                Strobe <= Mask;  // Step every unmasked chip past its header
            end
            if (LoadEnable && LoadField == tkrMergePkg::FieldCluster) begin
                Strobe  <= chipBit;  // Pull the next word of the chip just loaded
                clusCnt <= (state == tkrMergePkg::ChipHdrSt) ? 4'd1 : clusCnt + 4'd1;
            end
            if (AdvanceChip) CurrentChip <= NextChip;
        end
    end

    assert property (@(posedge Clock) disable iff (reset) $onehot(state));

    // A masked chip may have no source behind it, so it must never be pulled
    assert property (@(posedge Clock) disable iff (reset) (Strobe & ~Mask) == '0);

endmodule

//--- verilog/chipHeaderBank.sv
/*
 * Holds the event headers of all chips for the frame being sent.
 * Checks tag agreement, counts chips with clusters and finds the next chip to read out.
 */
`timescale 1ns/10ps

module chipHeaderBank #(
    parameter int NumChips = 12
) (
    input  logic                                   Clock,
    input  logic                                   reset,
    input  logic [NumChips-1:0]                    Mask,
    input  tkrMergePkg::chipWord_t [NumChips-1:0]  ChipWords,
    input  logic                                   LatchHeaders,
    input  logic [3:0]                             CurrentChip,
    input  logic                                   AdvanceChip,
    output tkrMergePkg::eventHeader_t              HeaderOut,
    output tkrMergePkg::chipFrameHeader_t          ChipHeaderOut,
    output logic [3:0]                             NClusCurrent,
    output logic [3:0]                             NextChip,
    output logic                                   NoMoreChips,
    output logic                                   TagErr
);

    tkrMergePkg::chipHeader_t [NumChips-1:0] hdr;
    tkrMergePkg::chipHeader_t                nextHdr;
    logic [NumChips-1:0] live;     // Mask as it was when the headers were taken
    logic                atStart;  // No chip header sent yet, so chip 0 is eligible
    logic [1:0]          refTag;
    logic [3:0]          chipsWithClus;

    always_ff @(posedge Clock) begin
        if (LatchHeaders) begin
            for (int i = 0; i < NumChips; i++) hdr[i] <= ChipWords[i].header;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            live    <= '0;
            atStart <= 1'b0;
        end else if (LatchHeaders) begin
            live    <= Mask;
            atStart <= 1'b1;
        end else if (AdvanceChip) begin
            atStart <= 1'b0;
        end
    end

    always_comb begin
        refTag        = 2'b00;
        TagErr        = 1'b0;
        chipsWithClus = '0;
        NextChip      = '0;
        NoMoreChips   = 1'b1;
        // Walk downwards so the lowest matching chip wins
        for (int i = NumChips - 1; i >= 0; i--) begin
            if (live[i]) refTag = hdr[i].tag;
            if (live[i] && hdr[i].nClus != 0 && (atStart || i > CurrentChip)) begin
                NextChip    = 4'(i);
                NoMoreChips = 1'b0;
            end
        end
        for (int i = 0; i < NumChips; i++) begin
            if (live[i] && hdr[i].tag != refTag) TagErr = 1'b1;
            if (live[i] && hdr[i].nClus != 0) chipsWithClus = chipsWithClus + 4'd1;
        end
    end

    assign nextHdr      = hdr[NextChip];
    assign NClusCurrent = hdr[CurrentChip].nClus;

    assign HeaderOut = '{evtNum: 5'd0, tag: refTag, tagErr: TagErr,
                         nChipsWithClus: chipsWithClus};  // Event number is added downstream

    assign ChipHeaderOut = '{overflow: nextHdr.overflow, zeroHi: 1'b0, nClus: nextHdr.nClus,
                             chipErr: nextHdr.chipErr, zeroLo: 1'b0, chip: NextChip};

    // A chip found at the start of a frame must be counted in the event header
    assert property (@(posedge Clock) disable iff (reset)
        (atStart && !NoMoreChips) |-> (chipsWithClus != 0));

endmodule

//--- verilog/frameShifter.sv
/*
 * Output shift register of the merger. Loads one frame field at a time and
 * shifts it out MSB first. Rests at 0 whenever no field is being sent.
 */
`timescale 1ns/10ps

module frameShifter #(
    parameter logic [3:0] BoardAddress = 4'h0
) (
    input  logic                          Clock,
    input  logic                          reset,
    input  logic                          LoadEnable,
    input  tkrMergePkg::frameField_t      LoadField,
    input  logic                          ShiftEnable,
    input  tkrMergePkg::eventHeader_t     HeaderOut,
    input  logic [4:0]                    EvtNum,
    input  tkrMergePkg::chipFrameHeader_t ChipHeaderOut,
    input  tkrMergePkg::chipWord_t        ClusterWord,
    output logic                          MergeDataOut
);

    localparam int PadBits = tkrMergePkg::WordBits - tkrMergePkg::StartBits;

    logic [tkrMergePkg::WordBits-1:0] shiftReg, fieldWord;
    tkrMergePkg::eventHeader_t        eventWord;

    always_comb begin
        eventWord        = HeaderOut;
        eventWord.evtNum = EvtNum;
        case (LoadField)
            tkrMergePkg::FieldStart: begin
                fieldWord = {tkrMergePkg::StartPrefix, BoardAddress, {PadBits{1'b0}}};
            end
            tkrMergePkg::FieldEvent: fieldWord = eventWord;
            tkrMergePkg::FieldChip:  fieldWord = ChipHeaderOut;
            default:                 fieldWord = ClusterWord.cluster;  // Raw cluster view
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            shiftReg <= '0;
        end else if (LoadEnable) begin
            shiftReg <= fieldWord;
        end else if (ShiftEnable) begin
            shiftReg <= {shiftReg[tkrMergePkg::WordBits-2:0], 1'b0};
        end else begin
            shiftReg <= '0;  // Keeps the line low between frames
        end
    end

    assign MergeDataOut = shiftReg[tkrMergePkg::WordBits-1];

endmodule

//--- verilog/eventBookkeeping.sv
/*
 * Event counters of the merger. Tracks send requests not yet served,
 * the 5-bit event number that follows the chip tag, and the frame count.
 */
`timescale 1ns/10ps

module eventBookkeeping (
    input  logic        Clock,
    input  logic        reset,
    input  logic        SendEvt,
    input  logic        FrameDone,
    input  logic        TagIsLast,
    output logic        HavePending,
    output logic [4:0]  EvtNum,
    output logic [15:0] Nevent
);

    logic [3:0] pending;  // Requests received but not yet sent

    always_ff @(posedge Clock) begin
        if (reset) begin
            pending <= '0;
            EvtNum  <= '0;
            Nevent  <= '0;
        end else begin
            if (SendEvt && !FrameDone) begin
                pending <= pending + 4'd1;
            end else if (FrameDone && !SendEvt) begin
                pending <= pending - 4'd1;
            end
            if (FrameDone) begin
                Nevent <= Nevent + 16'd1;
                if (TagIsLast) EvtNum <= EvtNum + 5'd1;  // Tag wraps after 3, so a new group starts
            end
        end
    end

    assign HavePending = (pending != 4'd0);

    // The FSM only finishes a frame it started on a pending request
    assert property (@(posedge Clock) disable iff (reset)
        !(pending == 4'd0 && FrameDone && !SendEvt));

    assert property (@(posedge Clock) disable iff (reset)
        !(pending == 4'hF && SendEvt && !FrameDone));

endmodule

//--- verilog/TkrDataMerge.sv
/*
 * Merges the readout of up to fifteen tracker front-end chips into one serial frame per event.
 * The frame FSM drives a header bank, a field shift register and the event counters.
 * NumChips and BoardAddress are set here and passed down.
 */
`timescale 1ns/10ps

module TkrDataMerge #(
    parameter int         NumChips     = 12,
    parameter logic [3:0] BoardAddress = 4'h5
) (
    input  logic                                     Clock,
    input  logic                                     reset,
    input  logic                                     SendEvt,
    input  logic [NumChips-1:0]                      Mask,
    input  logic [NumChips-1:0]                      ChipReady,
    input  tkrMergePkg::chipWord_t [NumChips-1:0]    ChipWords,
    output logic [NumChips-1:0]                      Strobe,
    output logic                                     MergeDataOut,
    output logic                                     ErrorOut,
    output logic [15:0]                              Nevent
);

    tkrMergePkg::frameField_t      LoadField;
    tkrMergePkg::eventHeader_t     HeaderOut;
    tkrMergePkg::chipFrameHeader_t ChipHeaderOut;
    tkrMergePkg::chipWord_t        ClusterWord;
    logic       LoadEnable, ShiftEnable, LatchHeaders, AdvanceChip, FrameDone;
    logic       NoMoreChips, TagErr, HavePending, TagIsLast;
    logic [3:0] CurrentChip, NextChip, NClusCurrent;
    logic [4:0] EvtNum;

    if (NumChips > tkrMergePkg::MaxChips) begin : gChipCheck
        $error("NumChips does not fit the 4-bit chip index");
    end

    assign ClusterWord = ChipWords[CurrentChip];   // Only the chip being read out feeds the shifter
    assign TagIsLast   = (HeaderOut.tag == 2'b11);

    mergeControl #(.NumChips(NumChips)) control (
        .Clock, .reset, .Mask, .ChipReady, .HavePending, .NoMoreChips, .NextChip,
        .NClusCurrent, .TagErr, .Strobe, .LatchHeaders, .LoadField, .LoadEnable,
        .ShiftEnable, .CurrentChip, .AdvanceChip, .FrameDone, .ErrorOut
    );

    chipHeaderBank #(.NumChips(NumChips)) headers (
        .Clock, .reset, .Mask, .ChipWords, .LatchHeaders, .CurrentChip, .AdvanceChip,
        .HeaderOut, .ChipHeaderOut, .NClusCurrent, .NextChip, .NoMoreChips, .TagErr
    );

    frameShifter #(.BoardAddress(BoardAddress)) shifter (
        .Clock, .reset, .LoadEnable, .LoadField, .ShiftEnable, .HeaderOut, .EvtNum,
        .ChipHeaderOut, .ClusterWord, .MergeDataOut
    );

    eventBookkeeping bookkeeping (
        .Clock, .reset, .SendEvt, .FrameDone, .TagIsLast, .HavePending, .EvtNum, .Nevent
    );

endmodule

//--- test/tkrMergeModel.svh
/*
 * Reference model of the merged frame, included in the testbench module.
 * Holds the generated events and builds the expected fields of one frame at a time.
 */
`ifndef TKR_MERGE_MODEL_SVH
`define TKR_MERGE_MODEL_SVH

    tkrMergePkg::chipHeader_t  evHdr[NumEvents][NumChips];
    logic [11:0]               evClus[NumEvents][NumChips][3];
    logic [NumChips-1:0]       evMask[NumEvents];

    tkrMergePkg::eventHeader_t expEvt;        // Event header of the frame being checked
    logic [11:0]               expFields[$];  // Chip headers and cluster words in frame order
    bit                        expIsHdr[$];
    int                        expLen;
    logic [4:0]                modelEvtNum;

    function automatic void buildFrame(int e);
        tkrMergePkg::chipFrameHeader_t ch;
        bit found;
        found = 1'b0;
        expEvt = '0;
        expEvt.evtNum = modelEvtNum;
        expFields.delete();
        expIsHdr.delete();
        for (int i = 0; i < NumChips; i++) begin
            if (evMask[e][i] && !found) begin
                expEvt.tag = evHdr[e][i].tag;  // Lowest unmasked chip gives the reported tag
                found = 1'b1;
            end else if (evMask[e][i] && evHdr[e][i].tag != expEvt.tag) begin
                expEvt.tagErr = 1'b1;
            end
        end
        for (int i = 0; i < NumChips; i++) begin
            if (evMask[e][i] && evHdr[e][i].nClus != 0) begin
                expEvt.nChipsWithClus = expEvt.nChipsWithClus + 4'd1;
                ch = '0;  // Both zero bits stay clear
                ch.overflow = evHdr[e][i].overflow;
                ch.nClus = evHdr[e][i].nClus;
                ch.chipErr = evHdr[e][i].chipErr;
                ch.chip = 4'(i);
                expFields.push_back(ch);
                expIsHdr.push_back(1'b1);
                for (int k = 0; k < int'(evHdr[e][i].nClus); k++) begin
                    expFields.push_back(evClus[e][i][k]);
                    expIsHdr.push_back(1'b0);
                end
            end
        end
        expLen = 18 + 12 * expFields.size();  // Start string and event header come first
    endfunction

    // The event number moves on once the tag has run through all four values
    function automatic void advanceEventNumber();
        if (expEvt.tag == 2'b11) modelEvtNum = modelEvtNum + 5'd1;
    endfunction

`endif

//--- test/tkrMergeTb.sv
/*
 * Testbench for TkrDataMerge. Random chip events come from an LFSR and reach the DUT
 * through per-chip source queues that follow the strobe handshake. The serial frames
 * are parsed from their leading 1 and checked against the included model.
 */
`timescale 1ns/10ps

module tkrMergeTb;

    localparam int         NumChips      = 12;
    localparam int         NumEvents     = 40;
    localparam logic [3:0] BoardAddress  = 4'hA;
    localparam int         MaxFrameBits  = 18 + 12 * 4 * NumChips;  // Every chip with 3 clusters
    localparam int         TimeoutCycles = NumEvents * MaxFrameBits + 200;

    logic                                  Clock, reset, SendEvt, MergeDataOut, ErrorOut;
    logic [NumChips-1:0]                   Mask, ChipReady, Strobe;
    tkrMergePkg::chipWord_t [NumChips-1:0] ChipWords;
    logic [15:0]                           Nevent;

    logic [31:0]         lfsr;
    logic [11:0]         srcQ[NumChips][$];  // Words each chip still has to present
    logic [NumChips-1:0] hdrFront, strobeSeen;
    bit                  frameBits[$];
    bit                  inFrame, loadDue;
    int                  gapLeft;  // Zero cycles still owed after a frame
    int                  framesDone, sentCount, curEvent, errPulses, sendGap, readyWait;
    int                  mismatches, failures, cycleCount;

    `include "tkrMergeModel.svh"

    TkrDataMerge #(.NumChips(NumChips), .BoardAddress(BoardAddress)) dut (.*);

    always #4 Clock = ~Clock;

    function automatic logic nextRandomBit();
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        return lfsr[0];
    endfunction

    function automatic logic [31:0] randomBits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[30:0], nextRandomBit()};
        return v;
    endfunction

    task automatic makeEvents();
        logic [1:0]  common;
        logic [11:0] raw;
        bit          split;
        for (int e = 0; e < NumEvents; e++) begin
            common = 2'(randomBits(2));
            split = (randomBits(3) == 0);  // About one event in eight gets mixed tags
            evMask[e] = NumChips'(randomBits(NumChips) | randomBits(NumChips));
            for (int i = 0; i < NumChips; i++) begin
                raw = 12'(randomBits(12));  // Spare bits, chipErr and overflow stay random
                evHdr[e][i] = raw;
                evHdr[e][i].tag = split ? 2'(randomBits(2)) : common;
                evHdr[e][i].nClus = 4'(randomBits(2));
                for (int k = 0; k < 3; k++) evClus[e][i][k] = 12'(randomBits(12));
            end
        end
    endtask

    task automatic checkEventHeader(tkrMergePkg::eventHeader_t got,
                                    tkrMergePkg::eventHeader_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("ERROR at %0t: event header got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkChipHeader(tkrMergePkg::chipFrameHeader_t got,
                                   tkrMergePkg::chipFrameHeader_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("ERROR at %0t: chip header got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkWord(string name, tkrMergePkg::chipWord_t got,
                             tkrMergePkg::chipWord_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Reads n frame bits MSB first and left-justifies them in a word
    function automatic logic [11:0] fieldAt(int pos, int n);
        logic [11:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[10:0], frameBits[pos + k]};
        return v << (12 - n);
    endfunction

    function automatic void loadSources(int e);
        for (int i = 0; i < NumChips; i++) begin
            if (evMask[e][i]) begin
                srcQ[i].push_back(evHdr[e][i]);
                for (int k = 0; k < int'(evHdr[e][i].nClus); k++) begin
                    srcQ[i].push_back(evClus[e][i][k]);
                end
                hdrFront[i] = 1'b1;
            end
        end
    endfunction

    task automatic checkFrame();
        int pos;
        pos = 18;
        checkWord("start string", fieldAt(0, 6), {2'b10, BoardAddress, 6'b000000});
        checkEventHeader(fieldAt(6, 12), expEvt);
        foreach (expFields[k]) begin
            if (expIsHdr[k]) checkChipHeader(fieldAt(pos, 12), expFields[k]);
            else checkWord("cluster word", fieldAt(pos, 12), expFields[k]);
            pos += 12;
        end
        if (errPulses != int'(expEvt.tagErr)) begin
            failures++;
            $display("ErrorOut pulsed %0d times in frame %0d but the tag check expects %0d",
                     errPulses, framesDone, expEvt.tagErr);
        end
        framesDone++;
        advanceEventNumber();
    endtask

    // One cycle of stimulus, applied just after the rising edge
    task automatic driveCycle();
        for (int i = 0; i < NumChips; i++) begin
            if (strobeSeen[i]) begin
                if (srcQ[i].size() == 0) begin
                    failures++;
                    $display("Chip %0d was strobed with no word left in its source", i);
                end else begin
                    void'(srcQ[i].pop_front());
                end
                hdrFront[i] = 1'b0;
            end
        end
        if (framesDone > curEvent && curEvent < NumEvents - 1) begin
            curEvent++;
            Mask = evMask[curEvent];
            readyWait = randomBits(3);  // Chips become ready a few cycles later
            loadDue = 1'b1;
        end
        if (loadDue && readyWait == 0) begin
            loadSources(curEvent);
            loadDue = 1'b0;
        end else if (loadDue) begin
            readyWait--;
        end
        ChipReady = hdrFront;
        for (int i = 0; i < NumChips; i++) begin
            ChipWords[i].cluster = (srcQ[i].size() != 0) ? srcQ[i][0] : 12'hFFF;  // Junk if empty
        end
        SendEvt = 1'b0;
        if (sendGap != 0) begin
            sendGap--;
        end else if (sentCount < NumEvents && sentCount - framesDone < 8) begin
            SendEvt = 1'b1;
            sentCount++;
            sendGap = randomBits(6);
        end
    endtask

    // Outputs are sampled mid-cycle, where they are stable
    always @(negedge Clock) begin
        strobeSeen = Strobe;
        if (reset) begin
            inFrame = 1'b0;
        end else if (inFrame) begin
            frameBits.push_back(MergeDataOut);
            if (ErrorOut) errPulses++;
            if (frameBits.size() == expLen) begin
                checkFrame();
                inFrame = 1'b0;
                gapLeft = 2;
            end
        end else begin
            if (ErrorOut) begin
                failures++;
                $display("ErrorOut pulsed outside a frame at %0t", $time);
            end
            if (gapLeft != 0 && MergeDataOut) begin
                failures++;
                $display("Frame %0d ran on or was followed too soon by another frame",
                         framesDone - 1);
            end else if (MergeDataOut && framesDone >= NumEvents) begin
                failures++;
                $display("A frame started after all %0d events were sent", NumEvents);
            end else if (MergeDataOut) begin
                if (sentCount <= framesDone) begin
                    failures++;
                    $display("Frame %0d started without a pending send request", framesDone);
                end
                checkCount("Nevent", Nevent, 16'(framesDone));
                buildFrame(framesDone);
                frameBits.delete();
                frameBits.push_back(1'b1);
                errPulses = 0;
                inFrame = 1'b1;
            end
            if (gapLeft != 0) gapLeft--;
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            $display("Timeout after %0d cycles with %0d of %0d frames received",
                     cycleCount, framesDone, NumEvents);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        Clock = 1'b0;
        reset = 1'b1;
        SendEvt = 1'b0;
        Mask = '0;
        ChipReady = '0;
        ChipWords = '0;
        hdrFront = '0;
        gapLeft = 0;
        lfsr = 32'h4eb6_ea84;
        modelEvtNum = '0;
        makeEvents();
        repeat (16) @(posedge Clock);
        #1;
        reset = 1'b0;
        Mask = evMask[0];
        loadSources(0);
        ChipReady = hdrFront;
        while (framesDone < NumEvents) begin
            @(posedge Clock);
            #1;
            driveCycle();
        end
        repeat (40) begin  // Room for a stray frame or a late ErrorOut
            @(posedge Clock);
            #1;
            driveCycle();
        end
        if (inFrame) begin
            failures++;
            $display("The run ended in the middle of a frame");
        end
        checkCount("Nevent", Nevent, 16'(NumEvents));
        checkCount("frame count", 16'(framesDone), 16'(sentCount));
        $display("Frames %0d, value mismatches %0d, other failures %0d",
                 framesDone, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+test
verilog/tkrMergePkg.sv
verilog/mergeControl.sv
verilog/chipHeaderBank.sv
verilog/frameShifter.sv
verilog/eventBookkeeping.sv
verilog/TkrDataMerge.sv
test/tkrMergeTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and decides pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tkrMergeTb -f verilog.f \
    -o tkrMergeSim && ./obj_dir/tkrMergeSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
